/* design/disp_pkg.sv */
// display timing package
// 640x480 VGA raster constants, pixel color widths and pixel queue sizing

package disp_pkg;

    // ####################
    // horizontal timing, in clocks
    localparam int h_active = 640;
    localparam int h_front  = 16;
    localparam int h_sync   = 96;
    localparam int h_back   = 48;
    localparam int h_total  = h_active + h_front + h_sync + h_back;  // 800

    localparam int h_sync_start = h_active + h_front;
    localparam int h_sync_end   = h_sync_start + h_sync;

    // ####################
    // vertical timing, in lines
    localparam int v_active = 480;
    localparam int v_front  = 10;
    localparam int v_sync   = 2;
    localparam int v_back   = 33;
    localparam int v_total  = v_active + v_front + v_sync + v_back;  // 525

    localparam int v_sync_start = v_active + v_front;
    localparam int v_sync_end   = v_sync_start + v_sync;

    localparam int h_cnt_w = 10;
    localparam int v_cnt_w = 10;

    // color, R in the top byte
    localparam int color_w = 8;
    localparam int pixel_w = 3 * color_w;

    localparam int frame_pixels = h_active * v_active;        // 307200
    localparam int pix_idx_w    = $clog2(frame_pixels + 1);

    // pixel queue
    localparam int fifo_depth = 16;
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int fifo_cnt_w = $clog2(fifo_depth + 1);       // holds 0..fifo_depth

endpackage

/* design/mem_pkg.sv */
// memory port package
// frame buffer address and word sizes, read pipelining limit

package mem_pkg;

    localparam int addr_w = 26;             // byte address
    localparam int data_w = 32;             // one word per pixel

    localparam int bytes_per_pixel = 4;

    // memory answers within 8 cycles, so never more than 8 reads pending
    localparam int max_outstanding = 8;
    localparam int inflight_w      = $clog2(2 * max_outstanding);

endpackage

/* design/frame_regs.sv */
// frame registers
// shadow copies of the frame buffer base and display enable, so a frame
// is never torn, plus the sticky vertical blank flag for software

`timescale 1ns/1ps

module frame_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [mem_pkg::addr_w-1:0] disp_addr,
    input  logic                       disp_on,
    input  logic                       clr_vblank,
    input  logic                       frame_start,
    input  logic                       vblank_start,
    output logic [mem_pkg::addr_w-1:0] cur_addr,
    output logic                       cur_on,
    output logic                       vblank
);

    logic on_q;     // enable held for the rest of the frame

    // ####################
    // shadow registers
    //
    // the fetch runs ahead of the scan and starts on the next frame
    // at the top of vertical blanking, so the base is taken there.
    // the enable only matters at the pins and is taken at frame start
    always_ff @(posedge clk) begin
        if (rst) begin
            cur_addr <= '0;
            on_q     <= 1'b0;
        end else begin
            if (vblank_start) begin
                cur_addr <= disp_addr;
            end
            if (frame_start) begin
                on_q <= disp_on;
            end
        end
    end

    // new enable already applies to pixel 0 of the frame
    assign cur_on = frame_start ? disp_on : on_q;

    // ####################
    // vertical blank flag, set beats clear
    always_ff @(posedge clk) begin
        if (rst) begin
            vblank <= 1'b0;
        end else if (vblank_start) begin
            vblank <= 1'b1;
        end else if (clr_vblank) begin
            vblank <= 1'b0;
        end
    end

endmodule

/* design/raster_timing.sv */
// raster timing generator
// pixel and line counters for 640x480, active-low syncs, active area
// and the frame start / vblank start events

`timescale 1ns/1ps

module raster_timing (
    input  logic                        clk,
    input  logic                        rst,
    output logic [disp_pkg::h_cnt_w-1:0] h_cnt,
    output logic [disp_pkg::v_cnt_w-1:0] v_cnt,
    output logic                        active,
    output logic                        hs_raw,
    output logic                        vs_raw,
    output logic                        frame_start,
    output logic                        vblank_start
);

    import disp_pkg::*;

    logic h_last;
    logic v_last;
    logic primed;       // queue has been filled once since reset

    assign h_last = (h_cnt == h_cnt_w'(h_total - 1));
    assign v_last = (v_cnt == v_cnt_w'(v_total - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt  <= '0;
            v_cnt  <= '0;
            primed <= 1'b0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
            // frame 0 starts with an empty queue, so it stays blank
            if (vblank_start) begin
                primed <= 1'b1;
            end
        end
    end

    // ####################
    // decoded raster outputs
    assign active = primed && (h_cnt < h_active) && (v_cnt < v_active);

    assign hs_raw = !((h_cnt >= h_sync_start) && (h_cnt < h_sync_end));
    assign vs_raw = !((v_cnt >= v_sync_start) && (v_cnt < v_sync_end));

    assign frame_start  = (h_cnt == '0) && (v_cnt == '0);
    assign vblank_start = (h_cnt == '0) && (v_cnt == v_cnt_w'(v_active));

    // both counters wrap inside one frame
    a_raster_range: assert property (@(posedge clk) disable iff (rst)
        (h_cnt < h_total) && (v_cnt < v_total))
        else $error("raster counter out of range h=%0d v=%0d", h_cnt, v_cnt);

endmodule

/* design/pixel_fetch.sv */
// pixel fetch
// reads the frame's pixels from memory in scan order, one word per pixel,
// keeping the pixel queue topped up ahead of the scan

`timescale 1ns/1ps

module pixel_fetch (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [mem_pkg::addr_w-1:0]     cur_addr,
    input  logic                           vblank_start,
    input  logic [disp_pkg::fifo_cnt_w-1:0] fill,
    input  logic                           rd_valid,
    input  logic [mem_pkg::data_w-1:0]     rd_data,
    output logic                           rd_req,
    output logic [mem_pkg::addr_w-1:0]     rd_addr,
    output logic                           push,
    output logic [disp_pkg::pixel_w-1:0]   push_data
);

    import disp_pkg::*;
    import mem_pkg::*;

    logic [pix_idx_w-1:0]  pix_idx;     // next pixel to request
    logic [inflight_w-1:0] in_flight;   // issued in earlier cycles, not yet back
    logic [fifo_cnt_w:0]   committed;   // queue slots spoken for
    logic                  done;
    logic                  can_issue;

    assign done      = (pix_idx == pix_idx_w'(frame_pixels));
    assign committed = (fifo_cnt_w + 1)'(fill) + (fifo_cnt_w + 1)'(in_flight)
                     + (fifo_cnt_w + 1)'(rd_req);
    assign can_issue = !done && (committed < fifo_depth);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_req    <= 1'b0;
            pix_idx   <= '0;
            in_flight <= '0;
        end else begin
            case ({rd_req, rd_valid})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: ;
            endcase

            if (vblank_start) begin     // queue is flushed, start the next frame
                rd_req  <= 1'b0;
                pix_idx <= '0;
            end else begin
                rd_req <= can_issue;
                if (can_issue) begin
                    pix_idx <= pix_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (can_issue) begin
            rd_addr <= cur_addr + addr_w'(pix_idx) * addr_w'(bytes_per_pixel);
        end
    end

    // low 24 bits carry RGB, top byte is ignored
    assign push      = rd_valid;
    assign push_data = rd_data[pixel_w-1:0];

    // memory latency contract
    a_inflight_max: assert property (@(posedge clk) disable iff (rst)
        in_flight <= max_outstanding)
        else $error("too many reads in flight: %0d", in_flight);

    a_valid_owed: assert property (@(posedge clk) disable iff (rst)
        rd_valid |-> (in_flight != '0))
        else $error("rd_valid without an outstanding read");

endmodule

/* design/pixel_queue.sv */
// pixel queue
// show-ahead FIFO between the memory returns and the scan

`timescale 1ns/1ps

module pixel_queue (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           flush,
    input  logic                           push,
    input  logic [disp_pkg::pixel_w-1:0]   push_data,
    input  logic                           pop,
    output logic [disp_pkg::pixel_w-1:0]   pop_data,
    output logic [disp_pkg::fifo_cnt_w-1:0] fill
);

    import disp_pkg::*;

    logic [pixel_w-1:0]    mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps at fifo_depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign pop_data = mem[rd_ptr];  // head, valid whenever fill is nonzero

    a_no_overflow: assert property (@(posedge clk) disable iff (rst || flush)
        push |-> (fill != fifo_cnt_w'(fifo_depth)))
        else $error("pixel queue push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst || flush)
        pop |-> (fill != '0))
        else $error("pixel queue pop while empty, fetch fell behind");

endmodule

/* design/video_out.sv */
// video output stage
// one register stage in front of the VGA pins, color split into channels,
// black while blanking or while the display is switched off

`timescale 1ns/1ps

module video_out (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         active,
    input  logic                         hs_raw,
    input  logic                         vs_raw,
    input  logic                         cur_on,
    input  logic [disp_pkg::pixel_w-1:0] pop_data,
    output logic [disp_pkg::color_w-1:0] vga_r,
    output logic [disp_pkg::color_w-1:0] vga_g,
    output logic [disp_pkg::color_w-1:0] vga_b,
    output logic                         vga_hs,
    output logic                         vga_vs,
    output logic                         vga_blank_n
);

    import disp_pkg::*;

    // sync and blank, inactive out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            vga_hs      <= 1'b1;
            vga_vs      <= 1'b1;
            vga_blank_n <= 1'b0;
        end else begin
            vga_hs      <= hs_raw;
            vga_vs      <= vs_raw;
            vga_blank_n <= active;
        end
    end

    // ####################
    // color channels
    always_ff @(posedge clk) begin
        if (active && cur_on) begin
            vga_r <= pop_data[2*color_w +: color_w];
            vga_g <= pop_data[color_w +: color_w];
            vga_b <= pop_data[0 +: color_w];
        end else begin
            vga_r <= '0;    // black outside the picture
            vga_g <= '0;
            vga_b <= '0;
        end
    end

endmodule

/* design/display.sv */
// frame buffer display top level
// frame registers, raster timing, pixel fetch and queue, VGA output stage

`timescale 1ns/1ps

module display (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [mem_pkg::addr_w-1:0]   disp_addr,
    input  logic                         disp_on,
    input  logic                         clr_vblank,
    input  logic                         rd_valid,
    input  logic [mem_pkg::data_w-1:0]   rd_data,
    output logic                         vblank,
    output logic                         rd_req,
    output logic [mem_pkg::addr_w-1:0]   rd_addr,
    output logic [disp_pkg::color_w-1:0] vga_r,
    output logic [disp_pkg::color_w-1:0] vga_g,
    output logic [disp_pkg::color_w-1:0] vga_b,
    output logic                         vga_hs,
    output logic                         vga_vs,
    output logic                         vga_blank_n
);

    import disp_pkg::*;
    import mem_pkg::*;

    logic [addr_w-1:0]     cur_addr;
    logic                  cur_on;
    logic                  frame_start, vblank_start;
    logic                  active, hs_raw, vs_raw;
    logic                  push;
    logic [pixel_w-1:0]    push_data, pop_data;
    logic [fifo_cnt_w-1:0] fill;

    frame_regs u_regs (
        .clk, .rst, .disp_addr, .disp_on, .clr_vblank,
        .frame_start, .vblank_start, .cur_addr, .cur_on, .vblank
    );

    // raster position is not needed past the decoded outputs
    raster_timing u_timing (
        .clk, .rst, .h_cnt(), .v_cnt(), .active, .hs_raw, .vs_raw,
        .frame_start, .vblank_start
    );

    pixel_fetch u_fetch (
        .clk, .rst, .cur_addr, .vblank_start, .fill, .rd_valid, .rd_data,
        .rd_req, .rd_addr, .push, .push_data
    );

    pixel_queue u_queue (
        .clk, .rst, .flush(vblank_start), .push, .push_data,
        .pop(active), .pop_data, .fill
    );

    video_out u_out (
        .clk, .rst, .active, .hs_raw, .vs_raw, .cur_on, .pop_data,
        .vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs, .vga_blank_n
    );

endmodule

/* tests/display_tb.sv */
// display testbench
// runs the frame buffer display against an in-order memory model with random
// latency, and checks reset, raster timing, pixel data, vblank and base switching

`timescale 1ns/1ps

module display_tb;

    // ####################
    // expected raster numbers
    localparam int line_cycles    = 800;
    localparam int hs_low         = 96;
    localparam int frame_cycles   = 525 * line_cycles;      // 420000
    localparam int vs_low         = 2 * line_cycles;
    localparam int lines_active   = 480;
    localparam int px_line        = 640;
    localparam int px_frame       = px_line * lines_active;
    localparam int timeout_cycles = frame_cycles * 4 * 11 / 10;

    localparam logic [25:0] base_a = 26'h001_0000;
    localparam logic [25:0] base_b = 26'h020_0000;

    logic        clk;
    logic        rst;
    logic [25:0] disp_addr;
    logic        disp_on;
    logic        clr_vblank;
    logic        rd_valid;
    logic [31:0] rd_data;
    logic        vblank;
    logic        rd_req;
    logic [25:0] rd_addr;
    logic [7:0]  vga_r, vga_g, vga_b;
    logic        vga_hs, vga_vs, vga_blank_n;

    int     errors    = 0;
    int     cyc       = 0;
    bit     timed_out = 1'b0;
    integer seed      = 32'hb746e16f;

    display uut (
        .clk, .rst, .disp_addr, .disp_on, .clr_vblank, .rd_valid, .rd_data,
        .vblank, .rd_req, .rd_addr, .vga_r, .vga_g, .vga_b,
        .vga_hs, .vga_vs, .vga_blank_n
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // frame buffer word is the byte address xor a constant with RGB in the low 24 bits
    function automatic logic [23:0] word_at(input logic [31:0] byte_addr);
        logic [31:0] w;
        w = byte_addr ^ 32'h00a5c3f0;
        return w[23:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %0t %s: expected %0d, got %0d", $time, name, exp, got);
        end
    endtask

    // ####################
    // memory model answering in order after 2 to 8 cycles
    int          mem_cyc  = 0;
    int          last_due = 0;
    int          due_q[$];
    logic [31:0] data_q[$];

    always @(posedge clk) begin
        int lat;
        int due;
        mem_cyc++;
        if (rst) begin
            rd_valid <= 1'b0;
            due_q.delete();
            data_q.delete();
        end else begin
            if (due_q.size() != 0 && due_q[0] == mem_cyc) begin
                rd_valid <= 1'b1;
                rd_data  <= data_q.pop_front();
                void'(due_q.pop_front());
            end else begin
                rd_valid <= 1'b0;
            end
            if (rd_req) begin
                lat = 2 + ($unsigned($random(seed)) % 7);
                due = mem_cyc + lat - 1;        // valid is seen one edge later
                if (due <= last_due) begin
                    due = last_due + 1;         // keep answers in order
                end
                last_due = due;
                due_q.push_back(due);
                data_q.push_back({8'h00, word_at(32'(rd_addr))});
            end
        end
    end

    // ####################
    // pin monitor sampled on the falling edge
    logic        hs_q    = 1'b1;
    logic        vs_q    = 1'b1;
    logic        blank_q = 1'b0;
    int          hs_fall_n = 0, hs_fall_at = 0, hs_rise_at = 0;
    int          vs_fall_n = 0, vs_fall_at = 0, vs_rise_at = 0;
    int          row = 0, col = 0, frame_px = 0, frame_ok = 0;
    int          done_lines = 0, done_px = 0, done_ok = 0;
    logic [25:0] frame_base = '0;   // base expected for the frame being shown
    logic        frame_on   = 1'b0;

    always @(negedge clk) begin
        logic [23:0] exp_px;
        logic [23:0] got_px;
        if (rst === 1'b0) begin
            if (hs_q && !vga_hs) begin
                hs_fall_at = cyc;
                hs_fall_n++;
            end
            if (!hs_q && vga_hs) hs_rise_at = cyc;
            if (!vs_q && vga_vs) vs_rise_at = cyc;
            if (blank_q && !vga_blank_n) begin      // end of an active line
                check_value("pixels per line on vga_blank_n", col, px_line);
                row++;
                col = 0;
            end
            if (vga_blank_n) begin
                exp_px = frame_on ? word_at(32'(frame_base) + 4 * (row * px_line + col)) : '0;
                got_px = {vga_r, vga_g, vga_b};
                assert (got_px === exp_px) begin
                    frame_ok++;
                end else begin
                    errors++;
                    $display("MISMATCH %0t {vga_r,vga_g,vga_b}: expected %06h, got %06h",
                             $time, exp_px, got_px);
                end
                col++;
                frame_px++;
            end
            if (vs_q && !vga_vs) begin              // frame boundary inside blanking
                vs_fall_at = cyc;
                done_lines = row;
                done_px    = frame_px;
                done_ok    = frame_ok;
                row        = 0;
                col        = 0;
                frame_px   = 0;
                frame_ok   = 0;
                frame_base = disp_addr;
                frame_on   = disp_on;
                vs_fall_n++;
            end
        end
        hs_q    = vga_hs;
        vs_q    = vga_vs;
        blank_q = vga_blank_n;
    end

    // ####################
    // directed tests
    task automatic expect_idle_pins(input bit with_req);
        if (with_req) check_value("rd_req", rd_req, 0);
        check_value("vblank", vblank, 0);
        check_value("vga_blank_n", vga_blank_n, 0);
        check_value("vga_hs", vga_hs, 1);
        check_value("vga_vs", vga_vs, 1);
    endtask

    task automatic apply_reset();
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i == 7) rst <= 1'b0;
            @(negedge clk);
            expect_idle_pins(1'b1);
        end
        @(negedge clk);
        expect_idle_pins(1'b0);     // fetch may already be requesting
    endtask

    task automatic measure_sync_timing();
        int t0;
        wait (hs_fall_n == 1);      // first two lines after reset
        t0 = hs_fall_at;
        wait (hs_fall_n == 2);
        check_value("vga_hs period", hs_fall_at - t0, line_cycles);
        check_value("vga_hs low time", hs_rise_at - t0, hs_low);
        wait (vs_fall_n == 1);
        t0 = vs_fall_at;
        wait (vs_fall_n == 2);
        check_value("vga_vs period", vs_fall_at - t0, frame_cycles);
        check_value("vga_vs low time", vs_rise_at - t0, vs_low);
        check_value("active lines on vga_blank_n", done_lines, lines_active);
        check_value("active pixels per frame", done_px, px_frame);
    endtask

    task automatic verify_pixel_data();
        @(posedge clk);
        disp_addr <= base_a;
        disp_on   <= 1'b1;
        wait (vs_fall_n == 2);
        check_value("matching pixels on base A", done_ok, px_frame);
    endtask

    task automatic pulse_clear();
        @(posedge clk);
        clr_vblank <= 1'b1;
        @(posedge clk);
        clr_vblank <= 1'b0;
        @(negedge clk);
        check_value("vblank after clr_vblank", vblank, 0);
    endtask

    task automatic vblank_set_and_clear();
        int rise_at;
        while (vblank !== 1'b1) @(negedge clk);
        rise_at = cyc;
        check_value("vs falls before first vblank", vs_fall_n, 0);
        repeat (50) @(negedge clk);
        check_value("vblank held until cleared", vblank, 1);
        pulse_clear();
        repeat (50) @(negedge clk);
        check_value("vblank stays cleared", vblank, 0);
        while (vblank !== 1'b1) @(negedge clk);
        check_value("vblank rise spacing", cyc - rise_at, frame_cycles);
        check_value("active lines before vblank", row, lines_active);
        check_value("vga_blank_n at vblank rise", vga_blank_n, 0);
        pulse_clear();
    endtask

    task automatic switch_base_mid_frame();
        wait (vs_fall_n == 1 && row >= 240);
        @(posedge clk);
        disp_addr <= base_b;                        // mid-frame write
        wait (vs_fall_n == 2);
        check_value("pixels on old base after write", done_ok, px_frame);
        wait (vs_fall_n == 3);
        check_value("pixels on new base B", done_ok, px_frame);
    endtask

    task automatic blank_with_display_off();
        int t0;
        wait (vs_fall_n == 2 && row >= 240);
        @(posedge clk);
        disp_on <= 1'b0;
        wait (vs_fall_n == 3);
        t0 = vs_fall_at;
        wait (vs_fall_n == 4);
        check_value("black pixels with display off", done_ok, px_frame);
        check_value("active lines with display off", done_lines, lines_active);
        check_value("vga_vs period with display off", vs_fall_at - t0, frame_cycles);
        check_value("vga_vs low time with display off", vs_rise_at - t0, vs_low);
    endtask

    // ####################
    // run control
    task automatic summarize();
        $display("display_tb: %0d errors", errors);
        if (errors == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cyc++;
        if (cyc >= timeout_cycles) begin
            $display("timeout: tests still running after %0d cycles", timeout_cycles);
            timed_out = 1'b1;
            summarize();
        end
    end

    initial begin
        rst        <= 1'b1;
        disp_addr  <= '0;
        disp_on    <= 1'b0;
        clr_vblank <= 1'b0;
        rd_valid   <= 1'b0;
        rd_data    <= '0;
        apply_reset();
        fork    // frame 0 is blank and frames 1 to 3 overlap these tests
            measure_sync_timing();
            verify_pixel_data();
            vblank_set_and_clear();
            switch_base_mid_frame();
            blank_with_display_off();
        join
        summarize();
    end

endmodule

/* display.f */
design/disp_pkg.sv
design/mem_pkg.sv
design/frame_regs.sv
design/raster_timing.sv
design/pixel_fetch.sv
design/pixel_queue.sv
design/video_out.sv
design/display.sv
tests/display_tb.sv

/* Bender.yml */
package:
  name: display

sources:
  - design/disp_pkg.sv
  - design/mem_pkg.sv
  - design/frame_regs.sv
  - design/raster_timing.sv
  - design/pixel_fetch.sv
  - design/pixel_queue.sv
  - design/video_out.sv
  - design/display.sv
  - target: test
    files:
      - tests/display_tb.sv
